//--- mem_pipe_stimulus.txt
# R op rs1 rs2 imm trans priv fault data vaddr | F vtag ptag u w d | X flushes the TLB
# op lb0 lh1 lw2 lbu3 lhu4 sb5 sh6 sw7, priv u0 s1 m3, fault codes as in the package
R 7 00000100 deadbeef 00000010 0 3 0 00000000 00000110
R 2 00000100 00000000 00000010 0 3 0 deadbeef 00000110
R 5 00000200 000000a5 00000001 0 3 0 00000000 00000201
R 6 00000200 00008a7c 00000002 0 3 0 00000000 00000202
R 0 00000200 00000000 00000001 0 3 0 ffffffa5 00000201
R 3 00000201 00000000 00000000 0 3 0 000000a5 00000201
R 1 00000200 00000000 00000002 0 3 0 ffff8a7c 00000202
R 4 00000200 00000000 00000002 0 3 0 00008a7c 00000202
R 7 00000110 11111111 00000002 0 3 3 00000000 00000112
R 1 00000200 00000000 00000001 0 3 2 00000000 00000201
R 2 00000110 00000000 00000000 0 3 0 deadbeef 00000110
R 7 00002000 12345678 00000004 0 3 0 00000000 00002004
R 2 00005000 00000000 00000004 1 3 1 00000000 00005004
F 00005 02 0 1 1
R 2 00005000 00000000 00000004 1 3 0 12345678 00005004
X
R 2 00005000 00000000 00000004 1 3 1 00000000 00005004
F 00006 01 1 0 1
R 2 00006000 00000000 00000000 1 0 0 00000000 00006000
R 2 00006000 00000000 00000000 1 1 4 00000000 00006000
R 7 00006000 0000abcd 00000000 1 0 5 00000000 00006000
R 7 00006000 0000abcd 00000000 1 3 0 00000000 00006000
F 00007 03 0 1 0
R 2 00007000 00000000 00000000 1 0 4 00000000 00007000
R 6 00007000 00001234 00000000 1 1 5 00000000 00007000
R 2 00004000 00000000 00000000 0 3 6 00000000 00004000
F 00008 10 0 1 1
R 7 00008000 00000001 00000000 1 3 7 00000000 00008000

//--- mem_pipe.f
mem_pipe_pkg.sv
mem_pipe_wb_if.sv
mem_pipe_dtlb.sv
mem_pipe_fault_check.sv
mem_pipe_lsu.sv
mem_pipe_dmem.sv
mem_pipe_top.sv
mem_pipe_tb.sv

//--- mem_pipe_tb.sv
// Self-checking testbench for the load/store pipe; replays fill, flush and request records
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_tb
  import mem_pipe_pkg::*;
  ();

  localparam int wait_limit_lp = 64;

  logic                      clk_i;
  logic                      reset_i;
  logic                      valid_i;
  logic                      ready_o;
  mem_op_e                   op_i;
  logic [data_width_gp-1:0]  rs1_i;
  logic [data_width_gp-1:0]  rs2_i;
  logic [data_width_gp-1:0]  imm_i;
  logic                      translation_en_i;
  priv_e                     priv_i;
  logic                      flush_i;
  logic                      fill_v_i;
  logic [vtag_width_gp-1:0]  fill_vtag_i;
  tlb_entry_s                fill_entry_i;
  logic                      done_o;
  mem_fault_e                fault_o;
  logic [data_width_gp-1:0]  data_o;
  logic [vaddr_width_gp-1:0] vaddr_o;

  int unsigned lcg_state = 85;
  int          fault_errs;
  int          data_errs;
  int          vaddr_errs;
  int          ready_errs;
  int          other_errs;
  bit          timed_out;
  bit          eof_seen;
  int          rec_num;
  int          fd;
  int          rc;
  logic [63:0]   kind;
  logic [1023:0] line;
  logic [31:0]   f0, f1, f2, f3, f4, f5, f6, f7, f8;

  mem_pipe_top DUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_fault(input mem_fault_e got, input mem_fault_e exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: record %0d fault %s, expected %s",
               $time, rec_num, got.name(), exp.name());
      fault_errs++;
    end
  endtask

  task automatic check_data(input logic [data_width_gp-1:0] got,
                            input logic [data_width_gp-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: record %0d data %h, expected %h", $time, rec_num, got, exp);
      data_errs++;
    end
  endtask

  task automatic check_vaddr(input logic [vaddr_width_gp-1:0] got,
                             input logic [vaddr_width_gp-1:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: record %0d vaddr %h, expected %h", $time, rec_num, got, exp);
      vaddr_errs++;
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: record %0d ready_o %b, expected %b", $time, rec_num, got, exp);
      ready_errs++;
    end
  endtask

  task automatic apply_fill(input logic [31:0] vtag, input logic [31:0] ptag,
                            input logic [31:0] u, input logic [31:0] w,
                            input logic [31:0] d);
    @(posedge clk_i);
    fill_v_i     <= 1'b1;
    fill_vtag_i  <= vtag[vtag_width_gp-1:0];
    fill_entry_i <= '{ptag: ptag[ptag_width_gp-1:0], u: u[0], w: w[0], d: d[0]};
    @(posedge clk_i);
    fill_v_i <= 1'b0;
  endtask

  task automatic apply_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  task automatic run_request();
    int cnt;
    cnt = 0;
    @(negedge clk_i);
    while (!ready_o && cnt < wait_limit_lp) begin
      @(negedge clk_i);
      cnt++;
    end
    if (!ready_o) begin
      $display("Timeout at record %0d: ready_o never went high", rec_num);
      timed_out = 1'b1;
    end else begin
      @(posedge clk_i);
      valid_i          <= 1'b1;
      op_i             <= mem_op_e'(f0[2:0]);
      rs1_i            <= f1;
      rs2_i            <= f2;
      imm_i            <= f3;
      translation_en_i <= f4[0];
      priv_i           <= priv_e'(f5[1:0]);
      @(posedge clk_i);
      valid_i <= 1'b0;
      // Result sampled mid-cycle, away from the clock edge
      cnt = 0;
      @(negedge clk_i);
      while (!done_o && cnt < wait_limit_lp) begin
        // Busy until the result comes back
        check_ready(ready_o, 1'b0);
        @(negedge clk_i);
        cnt++;
      end
      if (!done_o) begin
        $display("Timeout at record %0d: done_o never went high", rec_num);
        timed_out = 1'b1;
      end else begin
        check_ready(ready_o, 1'b1);
        check_fault(fault_o, mem_fault_e'(f6[2:0]));
        check_data(data_o, f7);
        check_vaddr(vaddr_o, f8);
      end
    end
  endtask

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    valid_i          = 1'b0;
    op_i             = op_lw;
    rs1_i            = '0;
    rs2_i            = '0;
    imm_i            = '0;
    translation_en_i = 1'b0;
    priv_i           = priv_m;
    flush_i          = 1'b0;
    fill_v_i         = 1'b0;
    fill_vtag_i      = '0;
    fill_entry_i     = '0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    fd = $fopen("mem_pipe_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file mem_pipe_stimulus.txt");
      other_errs++;
    end else begin
      while (!eof_seen && !timed_out) begin
        rc = $fscanf(fd, "%s", kind);
        if (rc != 1) begin
          eof_seen = 1'b1;
        end else if (kind == "#") begin
          rc = $fgets(line, fd);
        end else begin
          rec_num++;
          if (kind == "F") begin
            rc = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
            apply_fill(f0, f1, f2, f3, f4);
          end else if (kind == "X") begin
            apply_flush();
          end else if (kind == "R") begin
            rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                         f0, f1, f2, f3, f4, f5, f6, f7, f8);
            run_request();
          end else begin
            $display("Unknown record kind at record %0d of the stimulus file", rec_num);
            other_errs++;
            eof_seen = 1'b1;
          end
          // Idle gap of 0 to 3 cycles
          repeat (lcg_next() >> 30) @(posedge clk_i);
        end
      end
      $fclose(fd);
    end
    $display("Errors: fault %0d, data %0d, vaddr %0d, ready %0d, other %0d, timeout %0d",
             fault_errs, data_errs, vaddr_errs, ready_errs, other_errs, timed_out);
    if (!timed_out
        && (fault_errs + data_errs + vaddr_errs + ready_errs + other_errs) == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mem_pipe_top.sv
// Top level of the load/store pipe and its data memory, joined by the Wishbone bus
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_top
  import mem_pipe_pkg::*;
  #(parameter int tlb_els_p     = 4
    , parameter int dmem_pages_p  = 4
    , parameter int wait_states_p = 1
    )
  (input  logic                      clk_i
   , input  logic                      reset_i
   , input  logic                      valid_i
   , output logic                      ready_o
   , input  mem_op_e                   op_i
   , input  logic [data_width_gp-1:0]  rs1_i
   , input  logic [data_width_gp-1:0]  rs2_i
   , input  logic [data_width_gp-1:0]  imm_i
   , input  logic                      translation_en_i
   , input  priv_e                     priv_i
   , input  logic                      flush_i
   , input  logic                      fill_v_i
   , input  logic [vtag_width_gp-1:0]  fill_vtag_i
   , input  tlb_entry_s                fill_entry_i
   , output logic                      done_o
   , output mem_fault_e                fault_o
   , output logic [data_width_gp-1:0]  data_o
   , output logic [vaddr_width_gp-1:0] vaddr_o
   );

  mem_pipe_wb_if wb_bus ();

  mem_pipe_lsu #(
    .tlb_els_p    (tlb_els_p),
    .dmem_pages_p (dmem_pages_p)
  ) lsu (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .valid_i          (valid_i),
    .ready_o          (ready_o),
    .op_i             (op_i),
    .rs1_i            (rs1_i),
    .rs2_i            (rs2_i),
    .imm_i            (imm_i),
    .translation_en_i (translation_en_i),
    .priv_i           (priv_i),
    .flush_i          (flush_i),
    .fill_v_i         (fill_v_i),
    .fill_vtag_i      (fill_vtag_i),
    .fill_entry_i     (fill_entry_i),
    .done_o           (done_o),
    .fault_o          (fault_o),
    .data_o           (data_o),
    .vaddr_o          (vaddr_o),
    .wb               (wb_bus.master)
  );

  mem_pipe_dmem #(
    .dmem_pages_p  (dmem_pages_p),
    .wait_states_p (wait_states_p)
  ) dmem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb      (wb_bus.slave)
  );

endmodule

`default_nettype wire

//--- mem_pipe_dmem.sv
// On-chip data memory as a Wishbone classic slave with byte selects and fixed wait states
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_dmem
  import mem_pipe_pkg::*;
  #(parameter int dmem_pages_p  = 4
    , parameter int wait_states_p = 1
    )
  (input  logic          clk_i
   , input  logic          reset_i
   , mem_pipe_wb_if.slave  wb
   );

  localparam int words_lp     = dmem_pages_p * (1 << (page_offset_width_gp - 2));
  localparam int idx_width_lp = $clog2(words_lp);
  localparam int cnt_width_lp = (wait_states_p > 0) ? $clog2(wait_states_p + 1) : 1;

  logic [data_width_gp-1:0] mem_r [words_lp];
  logic [cnt_width_lp-1:0]  wait_cnt_r;
  logic [idx_width_lp-1:0]  idx;
  logic                     req;
  logic                     last_wait;

  // Ack cycle still shows stb, so it must not start a new access
  assign req       = wb.cyc && wb.stb && !wb.ack;
  assign idx       = wb.adr[idx_width_lp-1:0];
  assign last_wait = (wait_cnt_r == cnt_width_lp'(wait_states_p));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb.ack     <= 1'b0;
      wait_cnt_r <= '0;
      for (int i = 0; i < words_lp; i++)
        mem_r[i] <= '0;
    end else begin
      wb.ack <= 1'b0;
      if (req) begin
        if (last_wait) begin
          wb.ack     <= 1'b1;
          wait_cnt_r <= '0;
          if (wb.we) begin
            for (int b = 0; b < 4; b++) begin
              if (wb.sel[b])
                mem_r[idx][8*b +: 8] <= wb.dat_w[8*b +: 8];
            end
          end
        end else begin
          wait_cnt_r <= wait_cnt_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req && last_wait && !wb.we)
      wb.dat_r <= mem_r[idx];
  end

  a_ack_with_stb: assert property (@(posedge clk_i) disable iff (reset_i)
    wb.ack |-> wb.stb)
    else $error("dmem: ack without stb");

endmodule

`default_nettype wire

//--- mem_pipe_lsu.sv
// Load/store pipe: forms the address, translates and checks it, then runs one Wishbone access
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_lsu
  import mem_pipe_pkg::*;
  #(parameter int tlb_els_p    = 4
    , parameter int dmem_pages_p = 4
    )
  (input  logic                      clk_i
   , input  logic                      reset_i
   , input  logic                      valid_i
   , output logic                      ready_o
   , input  mem_op_e                   op_i
   , input  logic [data_width_gp-1:0]  rs1_i
   , input  logic [data_width_gp-1:0]  rs2_i
   , input  logic [data_width_gp-1:0]  imm_i
   , input  logic                      translation_en_i
   , input  priv_e                     priv_i
   , input  logic                      flush_i
   , input  logic                      fill_v_i
   , input  logic [vtag_width_gp-1:0]  fill_vtag_i
   , input  tlb_entry_s                fill_entry_i
   , output logic                      done_o
   , output mem_fault_e                fault_o
   , output logic [data_width_gp-1:0]  data_o
   , output logic [vaddr_width_gp-1:0] vaddr_o
   , mem_pipe_wb_if.master             wb
   );

  typedef enum logic [1:0] {
    state_idle,
    state_check,
    state_bus
  } state_e;

  state_e                    state_r;
  mem_op_e                   op_r;
  logic [vaddr_width_gp-1:0] eaddr_r;
  logic [data_width_gp-1:0]  rs2_r;
  logic                      trans_en_r;
  priv_e                     priv_r;
  logic                      done_r;
  mem_fault_e                fault_r;
  logic [data_width_gp-1:0]  data_r;

  logic                      tlb_hit;
  tlb_entry_s                tlb_entry;
  mem_fault_e                fault;
  logic [ptag_width_gp-1:0]  ptag;
  logic [paddr_width_gp-1:0] paddr;
  logic                      is_store;
  logic [3:0]                st_sel;
  logic [data_width_gp-1:0]  st_data;
  logic [7:0]                ld_byte;
  logic [15:0]               ld_half;
  logic [data_width_gp-1:0]  ld_data;

  mem_pipe_dtlb #(.tlb_els_p(tlb_els_p)) dtlb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (flush_i),
    .fill_v_i      (fill_v_i),
    .fill_vtag_i   (fill_vtag_i),
    .fill_entry_i  (fill_entry_i),
    .lookup_vtag_i (eaddr_r[page_offset_width_gp +: vtag_width_gp]),
    .hit_o         (tlb_hit),
    .entry_o       (tlb_entry)
  );

  mem_pipe_fault_check #(.dmem_pages_p(dmem_pages_p)) fault_check (
    .op_i             (op_r),
    .vaddr_i          (eaddr_r),
    .translation_en_i (trans_en_r),
    .priv_i           (priv_r),
    .tlb_hit_i        (tlb_hit),
    .tlb_entry_i      (tlb_entry),
    .fault_o          (fault),
    .ptag_o           (ptag)
  );

  assign paddr    = {ptag, eaddr_r[page_offset_width_gp-1:0]};
  assign is_store = op_r inside {op_sb, op_sh, op_sw};

  // Replicate store data across lanes, sel picks the live ones
  always_comb begin
    case (op_r)
      op_sb: begin
        st_sel  = 4'b0001 << eaddr_r[1:0];
        st_data = {4{rs2_r[7:0]}};
      end
      op_sh: begin
        st_sel  = 4'b0011 << {eaddr_r[1], 1'b0};
        st_data = {2{rs2_r[15:0]}};
      end
      op_sw: begin
        st_sel  = 4'b1111;
        st_data = rs2_r;
      end
      default: begin
        st_sel  = 4'b1111;
        st_data = '0;
      end
    endcase
  end

  assign ld_byte = wb.dat_r[{eaddr_r[1:0], 3'b000} +: 8];
  assign ld_half = wb.dat_r[{eaddr_r[1], 4'b0000} +: 16];

  always_comb begin
    case (op_r)
      op_lb:   ld_data = {{24{ld_byte[7]}}, ld_byte};
      op_lbu:  ld_data = {24'b0, ld_byte};
      op_lh:   ld_data = {{16{ld_half[15]}}, ld_half};
      op_lhu:  ld_data = {16'b0, ld_half};
      op_lw:   ld_data = wb.dat_r;
      default: ld_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= state_idle;
      done_r  <= 1'b0;
      wb.cyc  <= 1'b0;
      wb.stb  <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state_r)
        state_idle: begin
          if (valid_i)
            state_r <= state_check;
        end
        state_check: begin
          if (fault != fault_none) begin
            done_r  <= 1'b1;
            state_r <= state_idle;
          end else begin
            wb.cyc  <= 1'b1;
            wb.stb  <= 1'b1;
            state_r <= state_bus;
          end
        end
        state_bus: begin
          if (wb.ack) begin
            wb.cyc  <= 1'b0;
            wb.stb  <= 1'b0;
            done_r  <= 1'b1;
            state_r <= state_idle;
          end
        end
        default: state_r <= state_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == state_idle && valid_i) begin
      op_r       <= op_i;
      eaddr_r    <= rs1_i + imm_i;
      rs2_r      <= rs2_i;
      trans_en_r <= translation_en_i;
      priv_r     <= priv_i;
    end
    if (state_r == state_check) begin
      fault_r  <= fault;
      data_r   <= '0;
      wb.we    <= is_store;
      wb.adr   <= paddr[paddr_width_gp-1:2];
      wb.sel   <= st_sel;
      wb.dat_w <= st_data;
    end
    if (state_r == state_bus && wb.ack)
      data_r <= ld_data;
  end

  assign ready_o = (state_r == state_idle);
  assign done_o  = done_r;
  assign fault_o = fault_r;
  assign data_o  = data_r;
  assign vaddr_o = eaddr_r;

  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    wb.stb |-> wb.cyc)
    else $error("lsu: stb without cyc");

  // Address held until the slave acknowledges
  a_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb.stb && !wb.ack) |=> $stable(wb.adr))
    else $error("lsu: adr changed during a pending strobe");

endmodule

`default_nettype wire

//--- mem_pipe_fault_check.sv
// Combinational fault classifier for one load/store: alignment, TLB miss, page and access faults
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_fault_check
  import mem_pipe_pkg::*;
  #(parameter int dmem_pages_p = 4
    )
  (input  mem_op_e                   op_i
   , input  logic [vaddr_width_gp-1:0] vaddr_i
   , input  logic                      translation_en_i
   , input  priv_e                     priv_i
   , input  logic                      tlb_hit_i
   , input  tlb_entry_s                tlb_entry_i
   , output mem_fault_e                fault_o
   , output logic [ptag_width_gp-1:0]  ptag_o
   );

  logic is_store;
  logic is_half;
  logic is_word;
  logic misaligned;
  logic priv_fault;
  logic write_fault;
  logic page_fault;
  logic access_fault;

  assign is_store = op_i inside {op_sb, op_sh, op_sw};
  assign is_half  = op_i inside {op_lh, op_lhu, op_sh};
  assign is_word  = op_i inside {op_lw, op_sw};

  // Passthrough takes the page number straight from the address
  assign ptag_o = translation_en_i
                ? tlb_entry_i.ptag
                : vaddr_i[page_offset_width_gp +: ptag_width_gp];

  assign misaligned = (is_half && vaddr_i[0]) || (is_word && (vaddr_i[1:0] != 2'b00));

  // M mode bypasses the u bit check
  assign priv_fault  = ((priv_i == priv_s) && tlb_entry_i.u)
                     || ((priv_i == priv_u) && !tlb_entry_i.u);
  assign write_fault = is_store && (!tlb_entry_i.w || !tlb_entry_i.d)
                     && (priv_i != priv_m);
  assign page_fault  = translation_en_i && (priv_fault || write_fault);

  assign access_fault = (ptag_o >= dmem_pages_p);

  always_comb begin
    if (misaligned)
      fault_o = is_store ? fault_store_misaligned : fault_load_misaligned;
    else if (translation_en_i && !tlb_hit_i)
      fault_o = fault_tlb_miss;
    else if (page_fault)
      fault_o = is_store ? fault_store_page : fault_load_page;
    else if (access_fault)
      fault_o = is_store ? fault_store_access : fault_load_access;
    else
      fault_o = fault_none;
  end

endmodule

`default_nettype wire

//--- mem_pipe_dtlb.sv
// Fully associative data TLB with fill and flush ports, looked up combinationally by the pipe
`timescale 1ns/1ps
`default_nettype none

module mem_pipe_dtlb
  import mem_pipe_pkg::*;
  #(parameter int tlb_els_p = 4
    )
  (input  logic                     clk_i
   , input  logic                     reset_i
   , input  logic                     flush_i
   , input  logic                     fill_v_i
   , input  logic [vtag_width_gp-1:0] fill_vtag_i
   , input  tlb_entry_s               fill_entry_i
   , input  logic [vtag_width_gp-1:0] lookup_vtag_i
   , output logic                     hit_o
   , output tlb_entry_s               entry_o
   );

  localparam int ptr_width_lp = (tlb_els_p > 1) ? $clog2(tlb_els_p) : 1;

  logic [tlb_els_p-1:0]     valid_r;
  logic [vtag_width_gp-1:0] tag_r [tlb_els_p];
  tlb_entry_s               entry_r [tlb_els_p];
  logic [ptr_width_lp-1:0]  repl_ptr_r;

  logic [tlb_els_p-1:0] fill_match;
  logic [tlb_els_p-1:0] fill_sel;
  logic [tlb_els_p-1:0] lookup_match;

  always_comb begin
    for (int i = 0; i < tlb_els_p; i++) begin
      fill_match[i]   = valid_r[i] && (tag_r[i] == fill_vtag_i);
      lookup_match[i] = valid_r[i] && (tag_r[i] == lookup_vtag_i);
    end
  end

  // Refill an existing mapping in place, else take the round-robin victim
  assign fill_sel = (|fill_match) ? fill_match : (tlb_els_p'(1) << repl_ptr_r);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r    <= '0;
      repl_ptr_r <= '0;
    end else if (flush_i) begin
      valid_r <= '0;
    end else if (fill_v_i) begin
      valid_r <= valid_r | fill_sel;
      if (!(|fill_match)) begin
        if (repl_ptr_r == ptr_width_lp'(tlb_els_p - 1))
          repl_ptr_r <= '0;
        else
          repl_ptr_r <= repl_ptr_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < tlb_els_p; i++) begin
      if (fill_v_i && !flush_i && fill_sel[i]) begin
        tag_r[i]   <= fill_vtag_i;
        entry_r[i] <= fill_entry_i;
      end
    end
  end

  assign hit_o = |lookup_match;

  always_comb begin
    entry_o = '0;
    for (int i = 0; i < tlb_els_p; i++) begin
      if (lookup_match[i])
        entry_o = entry_r[i];
    end
  end

  // Fills never leave two copies of one tag
  a_single_match: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(lookup_match))
    else $error("dtlb: several entries match one vtag");

endmodule

`default_nettype wire

//--- mem_pipe_wb_if.sv
// Wishbone classic bus between the load/store pipe (master) and the data memory (slave)
`timescale 1ns/1ps
`default_nettype none

interface mem_pipe_wb_if
  import mem_pipe_pkg::*;
  ();

  logic                      cyc;
  logic                      stb;
  logic                      we;
  // Word address
  logic [paddr_width_gp-3:0] adr;
  logic [3:0]                sel;
  logic [data_width_gp-1:0]  dat_w;
  logic [data_width_gp-1:0]  dat_r;
  logic                      ack;

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

//--- mem_pipe_pkg.sv
// Shared widths, opcodes, privilege modes, fault codes and TLB entry type for the load/store pipe
`default_nettype none

package mem_pipe_pkg;

  // Address and data widths
  parameter int vaddr_width_gp       = 32;
  parameter int page_offset_width_gp = 12;
  parameter int vtag_width_gp        = vaddr_width_gp - page_offset_width_gp;
  parameter int ptag_width_gp        = 8;
  parameter int paddr_width_gp       = ptag_width_gp + page_offset_width_gp;
  parameter int data_width_gp        = 32;

  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lh  = 3'd1,
    op_lw  = 3'd2,
    op_lbu = 3'd3,
    op_lhu = 3'd4,
    op_sb  = 3'd5,
    op_sh  = 3'd6,
    op_sw  = 3'd7
  } mem_op_e;

  // Encoded as in the mstatus.MPP field
  typedef enum logic [1:0] {
    priv_u = 2'd0,
    priv_s = 2'd1,
    priv_m = 2'd3
  } priv_e;

  typedef enum logic [2:0] {
    fault_none             = 3'd0,
    fault_tlb_miss         = 3'd1,
    fault_load_misaligned  = 3'd2,
    fault_store_misaligned = 3'd3,
    fault_load_page        = 3'd4,
    fault_store_page       = 3'd5,
    fault_load_access      = 3'd6,
    fault_store_access     = 3'd7
  } mem_fault_e;

  // Leaf PTE fields kept in the TLB
  typedef struct packed {
    logic [ptag_width_gp-1:0] ptag;
    logic                     u;
    logic                     w;
    logic                     d;
  } tlb_entry_s;

endpackage

`default_nettype wire
